// ==== Bender.yml ====
package:
  name: scalar_unit

sources:
  - source/scalar_pkg.sv
  - source/instr_mem.sv
  - source/pc_unit.sv
  - source/issue_ctrl.sv
  - source/reg_file.sv
  - source/scalar_alu.sv
  - source/scalar_unit.sv
  - target: simulation
    files:
      - verification/tb_clock.sv
      - verification/tb_scalar_unit.sv

// ==== source/instr_mem.sv ====
// Instruction memory
// Sequential store port with one-cycle acknowledge
// Registered fetch read that holds while fetch is disabled
module instr_mem (
	input  logic                               clock,
	input  logic                               reset,
	input  logic                               store_req,
	input  logic [scalar_pkg::instr_width-1:0] store_instr,
	output logic                               store_ack,
	input  logic                               fetch_en,
	input  logic [scalar_pkg::pc_width-1:0]    fetch_pc,
	output logic [scalar_pkg::instr_width-1:0] fetch_instr
);

	logic [scalar_pkg::instr_width-1:0] mem [scalar_pkg::imem_depth];
	logic [scalar_pkg::pc_width-1:0]    store_ptr;
	logic                               store_fire;

	// Request is still high in the ack cycle, so skip it there
	assign store_fire = store_req && !store_ack;

	// Store pointer and handshake
	always_ff @(posedge clock) begin
		if (reset) begin
			store_ptr <= '0;
			store_ack <= 1'b0;
		end else begin
			store_ack <= store_fire;
			if (store_fire) begin
				store_ptr <= store_ptr + 1'b1;	// Wraps at imem_depth
			end
		end
	end

	// Storage array and fetch read
	always_ff @(posedge clock) begin
		if (store_fire) begin
			mem[store_ptr] <= store_instr;
		end
		if (fetch_en) begin
			fetch_instr <= mem[fetch_pc];
		end
	end

endmodule

// ==== source/issue_ctrl.sv ====
// Issue stage
// Holding register, scoreboard, commit credit counter
// Issue block behind bnz and halt
module issue_ctrl (
	input  logic                                   clock,
	input  logic                                   reset,
	input  logic                                   fetch_valid,
	input  logic [scalar_pkg::instr_width-1:0]     fetch_instr,
	input  logic [scalar_pkg::pc_width-1:0]        fetch_pc,
	input  logic                                   wb_en,
	input  logic [scalar_pkg::reg_index_width-1:0] wb_dst,
	input  logic                                   commit_credit,
	input  logic                                   branch_done,
	output logic                                   issue_stall,
	output logic                                   read_valid,
	output scalar_pkg::opcode_e                    read_op,
	output logic [scalar_pkg::reg_index_width-1:0] read_dst,
	output logic [scalar_pkg::reg_index_width-1:0] read_src1,
	output logic [scalar_pkg::reg_index_width-1:0] read_src2,
	output logic [scalar_pkg::imm_width-1:0]       read_imm,
	output logic [scalar_pkg::pc_width-1:0]        read_pc
);

	logic                                  hold_valid;
	logic                                  hold_spec;	// Fetched behind a bnz or halt
	logic [scalar_pkg::instr_width-1:0]    hold_instr;
	logic [scalar_pkg::num_regs-1:0]       scoreboard;
	logic [scalar_pkg::credit_width-1:0]   credits;
	logic                                  ctrl_block;
	logic                                  hold_live;
	logic                                  writes_reg;
	logic                                  uses_src1;
	logic                                  uses_src2;
	logic                                  is_ctrl;
	logic                                  hazard;
	logic                                  can_issue;
	logic                                  issue;

	//////////////////////////////
	// Field decode
	assign read_op = scalar_pkg::opcode_e'(
		hold_instr[scalar_pkg::opcode_lsb +: scalar_pkg::opcode_width]);
	assign read_dst  = hold_instr[scalar_pkg::dst_lsb +: scalar_pkg::reg_index_width];
	assign read_src1 = hold_instr[scalar_pkg::src1_lsb +: scalar_pkg::reg_index_width];
	assign read_src2 = hold_instr[scalar_pkg::src2_lsb +: scalar_pkg::reg_index_width];
	assign read_imm  = hold_instr[scalar_pkg::imm_lsb +: scalar_pkg::imm_width];

	always_comb begin
		writes_reg = 1'b0;
		uses_src1  = 1'b0;
		uses_src2  = 1'b0;
		case (read_op)
			scalar_pkg::op_add, scalar_pkg::op_sub, scalar_pkg::op_and,
			scalar_pkg::op_or, scalar_pkg::op_xor: begin
				writes_reg = 1'b1;
				uses_src1  = 1'b1;
				uses_src2  = 1'b1;
			end
			scalar_pkg::op_addi: begin
				writes_reg = 1'b1;
				uses_src1  = 1'b1;
			end
			scalar_pkg::op_bnz: uses_src1 = 1'b1;
			default: ;	// nop, halt
		endcase
	end

	assign is_ctrl = (read_op == scalar_pkg::op_bnz) || (read_op == scalar_pkg::op_halt);

	//////////////////////////////
	// Issue decision
	// After a taken branch or halt, fetch_valid drops and the held word is wrong-path
	assign hold_live = hold_valid && !(hold_spec && !ctrl_block && !fetch_valid);

	assign hazard = (uses_src1 && scoreboard[read_src1])
		|| (uses_src2 && scoreboard[read_src2])
		|| (writes_reg && scoreboard[read_dst]);	// WAW

	assign can_issue   = !ctrl_block && !hazard && (!writes_reg || credits != '0);
	assign issue       = hold_live && can_issue;
	assign issue_stall = hold_live && !can_issue;
	assign read_valid  = issue;

	// Holding register payload
	always_ff @(posedge clock) begin
		if (!issue_stall) begin
			hold_instr <= fetch_instr;
			read_pc    <= fetch_pc - 1'b1;	// fetch_pc already points past this word
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			hold_valid <= 1'b0;
			hold_spec  <= 1'b0;
			ctrl_block <= 1'b0;
			scoreboard <= '0;
			credits    <= scalar_pkg::credit_width'(scalar_pkg::commit_credits);
		end else begin
			if (!issue_stall) begin
				hold_valid <= fetch_valid;
				hold_spec  <= ctrl_block || (issue && is_ctrl);
			end else if (!ctrl_block) begin
				hold_spec <= 1'b0;	// Branch fell through, word is kept
			end

			if (branch_done) begin
				ctrl_block <= 1'b0;
			end else if (issue && is_ctrl) begin
				ctrl_block <= 1'b1;
			end

			// Clear before set, WAW check keeps them apart
			if (wb_en) begin
				scoreboard[wb_dst] <= 1'b0;
			end
			if (issue && writes_reg) begin
				scoreboard[read_dst] <= 1'b1;
			end

			case ({issue && writes_reg, commit_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: ;	// Both or neither
			endcase
		end
	end

endmodule

// ==== source/pc_unit.sv ====
// Program counter and run state
// Start at address zero, advance, redirect, halt
module pc_unit (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            run,
	input  logic                            halt_seen,
	input  logic                            issue_stall,
	input  logic                            redirect,
	input  logic [scalar_pkg::pc_width-1:0] redirect_pc,
	output logic                            fetch_en,
	output logic [scalar_pkg::pc_width-1:0] fetch_pc,
	output logic                            fetch_valid,
	output logic                            busy
);

	// Fetch whenever running and issue can take the word
	assign fetch_en = busy && !issue_stall;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy        <= 1'b0;
			fetch_pc    <= '0;
			fetch_valid <= 1'b0;
		end else if (run && !busy) begin
			busy        <= 1'b1;
			fetch_pc    <= '0;
			fetch_valid <= 1'b0;
		end else if (halt_seen) begin
			// Word in flight is past the halt
			busy        <= 1'b0;
			fetch_valid <= 1'b0;
		end else if (redirect) begin
			fetch_pc    <= redirect_pc;
			fetch_valid <= 1'b0;	// Squash wrong-path word
		end else if (fetch_en) begin
			fetch_pc    <= fetch_pc + 1'b1;
			fetch_valid <= 1'b1;
		end
		// Stalled: PC and fetch_valid hold
	end

endmodule

// ==== source/reg_file.sv ====
// Register file
// Eight words, two registered read ports, one write port
module reg_file (
	input  logic                                   clock,
	input  logic                                   reset,
	input  logic [scalar_pkg::reg_index_width-1:0] read_src1,
	input  logic [scalar_pkg::reg_index_width-1:0] read_src2,
	input  logic                                   wb_en,
	input  logic [scalar_pkg::reg_index_width-1:0] wb_dst,
	input  logic [scalar_pkg::data_width-1:0]      wb_data,
	output logic [scalar_pkg::data_width-1:0]      src1_data,
	output logic [scalar_pkg::data_width-1:0]      src2_data
);

	logic [scalar_pkg::data_width-1:0] regs [scalar_pkg::num_regs];

	// Write port, registers start at zero
	always_ff @(posedge clock) begin
		if (reset) begin
			regs <= '{default: '0};
		end else if (wb_en) begin
			regs[wb_dst] <= wb_data;
		end
	end

	// Read ports line up with the execute stage
	// Scoreboard guarantees write-back lands first
	always_ff @(posedge clock) begin
		src1_data <= regs[read_src1];
		src2_data <= regs[read_src2];
	end

endmodule

// ==== source/scalar_alu.sv ====
// Execute stage
// ALU, branch resolution, write-back and commit record
module scalar_alu (
	input  logic                                   clock,
	input  logic                                   reset,
	input  logic                                   read_valid,
	input  scalar_pkg::opcode_e                    read_op,
	input  logic [scalar_pkg::reg_index_width-1:0] read_dst,
	input  logic [scalar_pkg::imm_width-1:0]       read_imm,
	input  logic [scalar_pkg::pc_width-1:0]        read_pc,
	input  logic [scalar_pkg::data_width-1:0]      src1_data,
	input  logic [scalar_pkg::data_width-1:0]      src2_data,
	output logic                                   wb_en,
	output logic [scalar_pkg::reg_index_width-1:0] wb_dst,
	output logic [scalar_pkg::data_width-1:0]      wb_data,
	output logic                                   commit_valid,
	output logic [scalar_pkg::reg_index_width-1:0] commit_dst,
	output logic [scalar_pkg::data_width-1:0]      commit_data,
	output logic                                   redirect,
	output logic [scalar_pkg::pc_width-1:0]        redirect_pc,
	output logic                                   branch_done,
	output logic                                   halt_seen
);

	logic                                   ex_valid;
	scalar_pkg::opcode_e                    ex_op;
	logic [scalar_pkg::reg_index_width-1:0] ex_dst;
	logic [scalar_pkg::imm_width-1:0]       ex_imm;
	logic [scalar_pkg::pc_width-1:0]        ex_pc;
	logic [scalar_pkg::data_width-1:0]      imm_ext;
	logic [scalar_pkg::data_width-1:0]      result;
	logic                                   writes;

	//////////////////////////////
	// Read stage control register
	always_ff @(posedge clock) begin
		if (reset) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= read_valid;
		end
	end

	always_ff @(posedge clock) begin
		ex_op  <= read_op;
		ex_dst <= read_dst;
		ex_imm <= read_imm;
		ex_pc  <= read_pc;
	end

	//////////////////////////////
	// ALU, wraps at 16 bits
	assign imm_ext = {{(scalar_pkg::data_width - scalar_pkg::imm_width){ex_imm[
		scalar_pkg::imm_width-1]}}, ex_imm};

	always_comb begin
		writes = 1'b1;
		case (ex_op)
			scalar_pkg::op_add:  result = src1_data + src2_data;
			scalar_pkg::op_sub:  result = src1_data - src2_data;
			scalar_pkg::op_and:  result = src1_data & src2_data;
			scalar_pkg::op_or:   result = src1_data | src2_data;
			scalar_pkg::op_xor:  result = src1_data ^ src2_data;
			scalar_pkg::op_addi: result = src1_data + imm_ext;
			default: begin
				result = '0;	// No register result
				writes = 1'b0;
			end
		endcase
	end

	//////////////////////////////
	// Write-back, commit and branch outputs
	always_ff @(posedge clock) begin
		if (reset) begin
			wb_en       <= 1'b0;
			redirect    <= 1'b0;
			branch_done <= 1'b0;
			halt_seen   <= 1'b0;
		end else begin
			wb_en       <= ex_valid && writes;
			redirect    <= ex_valid && (ex_op == scalar_pkg::op_bnz) && (src1_data != '0);
			// Halt also releases the issue block
			branch_done <= ex_valid && (ex_op == scalar_pkg::op_bnz
				|| ex_op == scalar_pkg::op_halt);
			halt_seen   <= ex_valid && (ex_op == scalar_pkg::op_halt);
		end
	end

	always_ff @(posedge clock) begin
		wb_dst      <= ex_dst;
		wb_data     <= result;
		redirect_pc <= ex_pc + ex_imm[scalar_pkg::pc_width-1:0];	// Low bits suffice, PC wraps
	end

	// Commit record is the write-back
	assign commit_valid = wb_en;
	assign commit_dst   = wb_dst;
	assign commit_data  = wb_data;

endmodule

// ==== source/scalar_pkg.sv ====
// Shared sizes of the scalar pipeline
// Opcode encoding and instruction field positions
package scalar_pkg;

	//////////////////////////////
	// Datapath and register file
	localparam int data_width      = 16;
	localparam int num_regs        = 8;
	localparam int reg_index_width = 3;

	// Instruction memory
	localparam int imem_depth  = 64;
	localparam int pc_width    = 6;
	localparam int instr_width = 24;

	// Commit stream flow control
	localparam int commit_credits = 4;
	localparam int credit_width   = 3;	// Counts 0 to commit_credits

	//////////////////////////////
	// Instruction word layout
	//   [23:20] opcode   [19:17] destination
	//   [16:14] source 1 [13:11] source 2
	//   [10:8]  spare, written as zero
	//   [7:0]   signed immediate
	localparam int opcode_width = 4;
	localparam int opcode_lsb   = 20;
	localparam int dst_lsb      = 17;
	localparam int src1_lsb     = 14;
	localparam int src2_lsb     = 11;
	localparam int imm_lsb      = 0;
	localparam int imm_width    = 8;

	//////////////////////////////
	// Opcodes
	typedef enum logic [opcode_width-1:0] {
		op_nop  = 4'd0,
		op_add  = 4'd1,
		op_sub  = 4'd2,
		op_and  = 4'd3,
		op_or   = 4'd4,
		op_xor  = 4'd5,
		op_addi = 4'd6,	// src1 plus sign-extended immediate
		op_bnz  = 4'd7,	// Branch relative to own address if src1 nonzero
		op_halt = 4'd8
	} opcode_e;

endpackage

// ==== source/scalar_unit.sv ====
// Scalar pipeline top level
// Store port, fetch, issue, register read, execute and commit
module scalar_unit (
	input  logic                                   clock,
	input  logic                                   reset,
	input  logic                                   store_req,
	input  logic [scalar_pkg::instr_width-1:0]     store_instr,
	output logic                                   store_ack,
	input  logic                                   run,
	output logic                                   busy,
	output logic                                   commit_valid,
	output logic [scalar_pkg::reg_index_width-1:0] commit_dst,
	output logic [scalar_pkg::data_width-1:0]      commit_data,
	input  logic                                   commit_credit
);

	// Fetch
	logic                                   fetch_en;
	logic [scalar_pkg::pc_width-1:0]        fetch_pc;
	logic [scalar_pkg::instr_width-1:0]     fetch_instr;
	logic                                   fetch_valid;
	logic                                   issue_stall;

	// Issue to read
	logic                                   read_valid;
	scalar_pkg::opcode_e                    read_op;
	logic [scalar_pkg::reg_index_width-1:0] read_dst;
	logic [scalar_pkg::reg_index_width-1:0] read_src1;
	logic [scalar_pkg::reg_index_width-1:0] read_src2;
	logic [scalar_pkg::imm_width-1:0]       read_imm;
	logic [scalar_pkg::pc_width-1:0]        read_pc;
	logic [scalar_pkg::data_width-1:0]      src1_data;
	logic [scalar_pkg::data_width-1:0]      src2_data;

	// Execute feedback
	logic                                   wb_en;
	logic [scalar_pkg::reg_index_width-1:0] wb_dst;
	logic [scalar_pkg::data_width-1:0]      wb_data;
	logic                                   redirect;
	logic [scalar_pkg::pc_width-1:0]        redirect_pc;
	logic                                   branch_done;
	logic                                   halt_seen;

	instr_mem u_instr_mem (
		.clock       (clock),
		.reset       (reset),
		.store_req   (store_req),
		.store_instr (store_instr),
		.store_ack   (store_ack),
		.fetch_en    (fetch_en),
		.fetch_pc    (fetch_pc),
		.fetch_instr (fetch_instr)
	);

	pc_unit u_pc_unit (
		.clock       (clock),
		.reset       (reset),
		.run         (run),
		.halt_seen   (halt_seen),
		.issue_stall (issue_stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.fetch_en    (fetch_en),
		.fetch_pc    (fetch_pc),
		.fetch_valid (fetch_valid),
		.busy        (busy)
	);

	issue_ctrl u_issue_ctrl (
		.clock         (clock),
		.reset         (reset),
		.fetch_valid   (fetch_valid),
		.fetch_instr   (fetch_instr),
		.fetch_pc      (fetch_pc),
		.wb_en         (wb_en),
		.wb_dst        (wb_dst),
		.commit_credit (commit_credit),
		.branch_done   (branch_done),
		.issue_stall   (issue_stall),
		.read_valid    (read_valid),
		.read_op       (read_op),
		.read_dst      (read_dst),
		.read_src1     (read_src1),
		.read_src2     (read_src2),
		.read_imm      (read_imm),
		.read_pc       (read_pc)
	);

	reg_file u_reg_file (
		.clock     (clock),
		.reset     (reset),
		.read_src1 (read_src1),
		.read_src2 (read_src2),
		.wb_en     (wb_en),
		.wb_dst    (wb_dst),
		.wb_data   (wb_data),
		.src1_data (src1_data),
		.src2_data (src2_data)
	);

	scalar_alu u_scalar_alu (
		.clock        (clock),
		.reset        (reset),
		.read_valid   (read_valid),
		.read_op      (read_op),
		.read_dst     (read_dst),
		.read_imm     (read_imm),
		.read_pc      (read_pc),
		.src1_data    (src1_data),
		.src2_data    (src2_data),
		.wb_en        (wb_en),
		.wb_dst       (wb_dst),
		.wb_data      (wb_data),
		.commit_valid (commit_valid),
		.commit_dst   (commit_dst),
		.commit_data  (commit_data),
		.redirect     (redirect),
		.redirect_pc  (redirect_pc),
		.branch_done  (branch_done),
		.halt_seen    (halt_seen)
	);

endmodule

// ==== src.f ====
source/scalar_pkg.sv
source/instr_mem.sv
source/pc_unit.sv
source/issue_ctrl.sv
source/reg_file.sv
source/scalar_alu.sv
source/scalar_unit.sv
verification/tb_clock.sv
verification/tb_scalar_unit.sv

// ==== verification/tb_clock.sv ====
// Testbench clock and reset source
// 4 ns clock, reset held for three cycles
module tb_clock (
	output logic clock,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset <= 1'b0;	// Released on a falling edge
	end

endmodule

// ==== verification/tb_scalar_unit.sv ====
// Testbench for the scalar pipeline
// Program images, reference model, commit checks, credit return and timeout
module tb_scalar_unit;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int num_programs = 2;
	localparam int cycle_limit  = 400 * num_programs;
	localparam int record_width = scalar_pkg::reg_index_width + scalar_pkg::data_width;

	logic                                   clock;
	logic                                   reset;
	logic                                   store_req;
	logic [scalar_pkg::instr_width-1:0]     store_instr;
	logic                                   store_ack;
	logic                                   run;
	logic                                   busy;
	logic                                   commit_valid;
	logic [scalar_pkg::reg_index_width-1:0] commit_dst;
	logic [scalar_pkg::data_width-1:0]      commit_data;
	logic                                   commit_credit = 1'b0;

	logic [31:0]                        rand_state;
	logic [scalar_pkg::instr_width-1:0] image [num_programs][scalar_pkg::imem_depth];
	logic [scalar_pkg::data_width-1:0]  model_regs [scalar_pkg::num_regs];
	logic [record_width-1:0]            expected_q [$];	// {dst, data} in commit order
	logic [record_width-1:0]            exp_rec;
	int                                 exp_count [num_programs];
	int                                 value_errors = 0;
	int                                 other_errors = 0;
	int                                 owed = 0;	// Records not yet credited back
	int                                 gap = 0;
	int                                 cycle_count = 0;
	logic                               withhold = 1'b0;

	tb_clock u_tb_clock (
		.clock (clock),
		.reset (reset)
	);

	scalar_unit u_scalar_unit (
		.clock         (clock),
		.reset         (reset),
		.store_req     (store_req),
		.store_instr   (store_instr),
		.store_ack     (store_ack),
		.run           (run),
		.busy          (busy),
		.commit_valid  (commit_valid),
		.commit_dst    (commit_dst),
		.commit_data   (commit_data),
		.commit_credit (commit_credit)
	);

	//////////////////////////////
	// Helpers
	function automatic logic [31:0] next_random();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	function automatic logic [7:0] random_byte();
		logic [31:0] r;
		r = next_random();
		return r[23:16];	// Upper bits, low LCG bits are weak
	endfunction

	function automatic logic [scalar_pkg::instr_width-1:0] encode(
		input scalar_pkg::opcode_e op, input logic [2:0] dst,
		input logic [2:0] src1, input logic [2:0] src2, input logic [7:0] imm);
		return {op, dst, src1, src2, 3'b000, imm};
	endfunction

	task automatic compare_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		assert (actual === expected) else begin
			value_errors++;
			$display("** Error: %s = %h, expected %h at %0t", name, actual, expected, $time);
		end
	endtask

	task automatic predict_write(input int p, input logic [2:0] d,
		input logic [scalar_pkg::data_width-1:0] value);
		model_regs[d] = value;
		expected_q.push_back({d, value});
		exp_count[p]++;
	endtask

	//////////////////////////////
	// Program images
	task automatic build_images();
		logic [7:0] count;
		for (int p = 0; p < num_programs; p++) begin
			for (int a = 0; a < scalar_pkg::imem_depth; a++) begin
				image[p][a] = encode(scalar_pkg::op_halt, 0, 0, 0, 8'h00);
			end
		end
		// Dependent arithmetic chain, WAW on r1 and r2
		image[0][0]  = encode(scalar_pkg::op_addi, 1, 0, 0, random_byte());
		image[0][1]  = encode(scalar_pkg::op_addi, 2, 1, 0, random_byte());
		image[0][2]  = encode(scalar_pkg::op_add,  3, 1, 2, 8'h00);
		image[0][3]  = encode(scalar_pkg::op_sub,  4, 3, 1, 8'h00);
		image[0][4]  = encode(scalar_pkg::op_and,  5, 4, 3, 8'h00);
		image[0][5]  = encode(scalar_pkg::op_or,   6, 5, 2, 8'h00);
		image[0][6]  = encode(scalar_pkg::op_xor,  7, 6, 4, 8'h00);
		image[0][7]  = encode(scalar_pkg::op_addi, 1, 7, 0, random_byte());
		image[0][8]  = encode(scalar_pkg::op_add,  1, 1, 1, 8'h00);
		image[0][9]  = encode(scalar_pkg::op_sub,  2, 2, 7, 8'h00);
		image[0][10] = encode(scalar_pkg::op_halt, 0, 0, 0, 8'h00);
		image[0][11] = encode(scalar_pkg::op_addi, 7, 7, 0, 8'h01);	// Past halt
		// Counted loop, then a not-taken and a taken forward branch
		count = (random_byte() % 6) + 1;
		image[1][0]  = encode(scalar_pkg::op_xor,  1, 1, 1, 8'h00);
		image[1][1]  = encode(scalar_pkg::op_addi, 1, 1, 0, count);
		image[1][2]  = encode(scalar_pkg::op_xor,  3, 3, 3, 8'h00);
		image[1][3]  = encode(scalar_pkg::op_add,  3, 3, 2, 8'h00);	// Loop body
		image[1][4]  = encode(scalar_pkg::op_addi, 4, 3, 0, random_byte());
		image[1][5]  = encode(scalar_pkg::op_addi, 1, 1, 0, 8'hff);
		image[1][6]  = encode(scalar_pkg::op_bnz,  0, 1, 0, 8'hfd);	// Back to 3
		image[1][7]  = encode(scalar_pkg::op_addi, 5, 1, 0, 8'h07);
		image[1][8]  = encode(scalar_pkg::op_bnz,  0, 1, 0, 8'h04);	// r1 is zero here
		image[1][9]  = encode(scalar_pkg::op_addi, 6, 5, 0, 8'h01);
		image[1][10] = encode(scalar_pkg::op_bnz,  0, 5, 0, 8'h02);
		image[1][11] = encode(scalar_pkg::op_addi, 7, 7, 0, 8'h01);	// Skipped
		image[1][12] = encode(scalar_pkg::op_halt, 0, 0, 0, 8'h00);
		image[1][13] = encode(scalar_pkg::op_addi, 7, 7, 0, 8'h02);
	endtask

	//////////////////////////////
	// Reference model, ISA level
	task automatic run_model(input int p);
		logic [scalar_pkg::pc_width-1:0]    pc;
		logic [scalar_pkg::instr_width-1:0] word;
		logic [scalar_pkg::data_width-1:0]  imm_ext;
		logic [2:0]                         d;
		logic [2:0]                         s1;
		logic [2:0]                         s2;
		scalar_pkg::opcode_e                op;
		int                                 steps;
		bit                                 done;
		pc = '0;
		steps = 0;
		done = 1'b0;
		exp_count[p] = 0;
		while (!done && steps < 1000) begin
			word = image[p][pc];
			op = scalar_pkg::opcode_e'(word[23:20]);
			d = word[19:17];
			s1 = word[16:14];
			s2 = word[13:11];
			imm_ext = {{8{word[7]}}, word[7:0]};
			steps++;
			pc = pc + 1'b1;
			case (op)
				scalar_pkg::op_add:  predict_write(p, d, model_regs[s1] + model_regs[s2]);
				scalar_pkg::op_sub:  predict_write(p, d, model_regs[s1] - model_regs[s2]);
				scalar_pkg::op_and:  predict_write(p, d, model_regs[s1] & model_regs[s2]);
				scalar_pkg::op_or:   predict_write(p, d, model_regs[s1] | model_regs[s2]);
				scalar_pkg::op_xor:  predict_write(p, d, model_regs[s1] ^ model_regs[s2]);
				scalar_pkg::op_addi: predict_write(p, d, model_regs[s1] + imm_ext);
				scalar_pkg::op_bnz: begin
					if (model_regs[s1] != '0) begin
						pc = pc - 1'b1 + word[5:0];	// Relative to own address
					end
				end
				scalar_pkg::op_halt: done = 1'b1;
				default: ;
			endcase
		end
	endtask

	//////////////////////////////
	// Stimulus tasks, called on a falling edge
	task automatic store_word(input logic [scalar_pkg::instr_width-1:0] word);
		int waited;
		store_req = 1'b1;
		store_instr = word;
		waited = 0;
		do begin
			@(negedge clock);
			waited++;
		end while (!store_ack && waited < 8);
		assert (store_ack && waited == 1) else begin
			other_errors++;
			$display("Error: store acknowledge took %0d cycles instead of one", waited);
		end
		store_req = 1'b0;
		@(negedge clock);
	endtask

	task automatic start_run();
		run = 1'b1;
		@(negedge clock);
		run = 1'b0;
		compare_value("busy", busy, 1);
	endtask

	// Commit checks and credit return
	always @(negedge clock) begin
		commit_credit = 1'b0;
		if (!reset) begin
			assert (busy || !commit_valid) else begin
				other_errors++;
				$display("Error: commit record while the pipeline is idle at %0t", $time);
			end
			if (commit_valid) begin
				owed++;
				assert (owed <= scalar_pkg::commit_credits) else begin
					other_errors++;
					$display("Error: %0d records outstanding, more than the credits", owed);
				end
				if (expected_q.size() == 0) begin
					other_errors++;
					$display("Error: commit record arrived when none was expected");
				end else begin
					exp_rec = expected_q.pop_front();
					compare_value("commit_dst", commit_dst, exp_rec[record_width-1 -: 3]);
					compare_value("commit_data", commit_data, exp_rec[15:0]);
				end
			end
			if (!withhold && owed > 0) begin
				if (gap == 0) begin
					commit_credit = 1'b1;
					owed--;
					gap = next_random() % 4;	// Random spacing of credits
				end else begin
					gap--;
				end
			end
		end
	end

	// Run limit
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Errors: %0d value, %0d other", value_errors, other_errors + 1);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////////////
	// Main sequence
	initial begin
		int remaining;
		rand_state = 32'hfc57c102;
		store_req = 1'b0;
		store_instr = '0;
		run = 1'b0;
		for (int r = 0; r < scalar_pkg::num_regs; r++) begin
			model_regs[r] = '0;
		end
		build_images();
		for (int p = 0; p < num_programs; p++) begin
			run_model(p);
		end
		@(negedge clock);
		while (reset) @(negedge clock);
		compare_value("busy", busy, 0);
		compare_value("commit_valid", commit_valid, 0);
		compare_value("store_ack", store_ack, 0);
		for (int p = 0; p < num_programs; p++) begin
			for (int a = 0; a < scalar_pkg::imem_depth; a++) begin
				store_word(image[p][a]);	// Full image, pointer wraps to zero
			end
			withhold = (p == 0);
			start_run();
			if (p == 0) begin
				repeat (40) @(negedge clock);
				assert (owed == scalar_pkg::commit_credits) else begin
					other_errors++;
					$display("Error: %0d records while credits were held back", owed);
				end
				withhold = 1'b0;
			end
			while (busy) @(negedge clock);
			remaining = 0;
			for (int q = p + 1; q < num_programs; q++) begin
				remaining += exp_count[q];
			end
			assert (expected_q.size() == remaining) else begin
				other_errors++;
				$display("Error: program %0d ended with %0d records missing", p,
					expected_q.size() - remaining);
			end
			repeat (10) @(negedge clock);	// Quiet time after halt
		end
		while (owed != 0) @(negedge clock);
		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule
